// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run; the simulator's exit status is the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpu_tb -f sim.f -Mdir obj_dir
./obj_dir/Vcpu_tb

// ==== sim.f ====
+incdir+testbench
verilog/cpu_pkg.sv
verilog/pipe_ifs.sv
verilog/decode_ctrl.sv
verilog/forward.sv
verilog/stage_if.sv
verilog/stage_id.sv
verilog/stage_ex.sv
verilog/stage_mem.sv
verilog/cpu.sv
testbench/cpu_tb.sv

// ==== testbench/cpu_tb_model.svh ====
// Instruction encoders, the branch target rule and a sequential reference interpreter.
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

function automatic cpu_pkg::word_t enc_alu(cpu_pkg::funct_e f, int rd, int rs, int rt);
	return {cpu_pkg::OP_ALU, 5'(rd), 5'(rs), 5'(rt), 7'b0, f};
endfunction

// SW stores register rd. Branches compare rs with rd.
function automatic cpu_pkg::word_t enc_imm(cpu_pkg::opcode_e op, int rd, int rs,
	logic [15:0] imm);
	return {op, 5'(rd), 5'(rs), imm};
endfunction

function automatic cpu_pkg::word_t branch_target(cpu_pkg::word_t pc, cpu_pkg::word_t instr);
	cpu_pkg::word_t offset;
	offset = {{16{instr[15]}}, instr[15:0]};
	return pc + 32'd4 + offset * 4;
endfunction

// Executes one instruction at a time until the program reaches its self-branch.
function automatic cpu_pkg::word_t reference_r1(cpu_pkg::word_t prog [16], int len,
	cpu_pkg::word_t start_pc);
	cpu_pkg::word_t r [32];
	cpu_pkg::word_t dm [64];
	cpu_pkg::word_t pc, ins, a, b, addr, next;
	int idx;
	logic taken;
	r = '{default: '0};
	dm = '{default: '0};
	pc = start_pc;
	repeat (256) begin
		idx = int'((pc - start_pc) >> 2);
		ins = (idx >= 0 && idx < len) ? prog[idx] : '0;
		a = r[ins[20:16]];
		b = r[ins[15:11]];
		addr = a + {{16{ins[15]}}, ins[15:0]};
		next = pc + 32'd4;
		case (cpu_pkg::opcode_e'(ins[31:26]))
			cpu_pkg::OP_ALU: begin
				case (cpu_pkg::funct_e'(ins[3:0]))
					cpu_pkg::F_ADD: r[ins[25:21]] = a + b;
					cpu_pkg::F_SUB: r[ins[25:21]] = a - b;
					cpu_pkg::F_AND: r[ins[25:21]] = a & b;
					cpu_pkg::F_OR: r[ins[25:21]] = a | b;
					cpu_pkg::F_XOR: r[ins[25:21]] = a ^ b;
					cpu_pkg::F_SLT: r[ins[25:21]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: ;
				endcase
			end
			cpu_pkg::OP_ADDI: r[ins[25:21]] = addr;
			cpu_pkg::OP_LUI: r[ins[25:21]] = {ins[15:0], 16'h0000};
			cpu_pkg::OP_LW: r[ins[25:21]] = dm[addr[7:2]];
			cpu_pkg::OP_SW: dm[addr[7:2]] = r[ins[25:21]];
			cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
				taken = (a == r[ins[25:21]]);
				if (cpu_pkg::opcode_e'(ins[31:26]) == cpu_pkg::OP_BNE) taken = !taken;
				if (taken) next = branch_target(pc, ins);
			end
			default: ;
		endcase
		r[0] = '0;
		if (next == pc) return r[1];
		pc = next;
	end
	return r[1];
endfunction

`endif

// ==== testbench/cpu_tb.sv ====
// Testbench for the pipelined core with its clock, program table, row loop, checks, LFSR and watchdog.
`timescale 1ns/1ps

module cpu_tb;

	localparam int CLK_NS = 4;
	localparam int NROWS = 11;
	localparam int PROG_WORDS = 16;
	localparam cpu_pkg::word_t RESET_PC = 32'h0000_0040;

	logic clk = 1'b0;
	logic rst = 1'b1;
	cpu_pkg::word_t instrmem_addr;
	cpu_pkg::word_t instrmem_data;
	cpu_pkg::word_t debug_out;
	cpu_pkg::word_t imem [64] = '{default: '0};

	string row_name [NROWS];
	cpu_pkg::word_t row_prog [NROWS][PROG_WORDS];
	int row_len [NROWS];
	int row_budget [NROWS];
	int row_chk [NROWS];
	int nrows = 0;
	cpu_pkg::word_t code [$];
	cpu_pkg::word_t lfsr_state = 32'h5552_6b9b;
	int errors = 0;
	int wd_cycles = 0;

	`include "cpu_tb_model.svh"

	cpu #(.RESET_PC(RESET_PC), .DMEM_WORDS(64), .DEBUG_REG(1)) dut_i (
		.clk(clk), .rst(rst), .instrmem_addr(instrmem_addr),
		.instrmem_data(instrmem_data), .debug_out(debug_out));

	// Instruction memory answers in the same cycle.
	assign instrmem_data = imem[instrmem_addr[7:2]];

	initial begin
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		wait (wd_cycles > 0);
		#(wd_cycles * CLK_NS);
		$display("watchdog: the tests did not finish within %0d cycles", wd_cycles);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	function automatic logic [15:0] take_bits16();
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hD000_0001 : lfsr_state >> 1;
		end
		return v;
	endfunction

	task automatic check_word(string test, cpu_pkg::word_t exp, cpu_pkg::word_t act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", test, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "register value check failed");
		end
	endtask

	task automatic check_pc(string test, cpu_pkg::word_t exp, cpu_pkg::word_t act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", test, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "fetch address check failed");
		end
	endtask

	// Closes the program with a self-branch and stores it as the next table row.
	task automatic add_row(string name, int budget, int chk);
		code.push_back(enc_imm(cpu_pkg::OP_BEQ, 0, 0, 16'hffff));
		row_name[nrows] = name;
		row_len[nrows] = code.size();
		row_budget[nrows] = budget;
		row_chk[nrows] = (chk < 0) ? code.size() - 1 : chk;
		for (int i = 0; i < PROG_WORDS; i++) begin
			row_prog[nrows][i] = (i < code.size()) ? code[i] : '0;
		end
		code.delete();
		nrows++;
	endtask

	//////////////////////////////
	// Program table.
	task automatic build_table();
		cpu_pkg::funct_e funcs [6] = '{cpu_pkg::F_ADD, cpu_pkg::F_SUB, cpu_pkg::F_AND,
			cpu_pkg::F_OR, cpu_pkg::F_XOR, cpu_pkg::F_SLT};
		string names [6] = '{"alu_add", "alu_sub", "alu_and", "alu_or", "alu_xor", "alu_slt"};
		logic [15:0] a, b;
		for (int i = 0; i < 6; i++) begin
			a = take_bits16();
			b = take_bits16();
			// A negative left operand and a non-negative right operand expose an unsigned SLT.
			if (funcs[i] == cpu_pkg::F_SLT) begin
				a[15] = 1'b1;
				b[15] = 1'b0;
			end
			code.push_back(enc_imm(cpu_pkg::OP_ADDI, 2, 0, a));
			code.push_back(enc_imm(cpu_pkg::OP_ADDI, 3, 0, b));
			code.push_back(enc_alu(funcs[i], 1, 2, 3));
			add_row(names[i], 24, -1);
		end
		code.push_back(enc_imm(cpu_pkg::OP_LUI, 1, 0, take_bits16()));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 1, 1, take_bits16()));
		add_row("lui_addi", 24, -1);
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 2, 0, take_bits16()));
		code.push_back(enc_alu(cpu_pkg::F_ADD, 3, 2, 2));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 4, 0, take_bits16()));
		code.push_back(enc_alu(cpu_pkg::F_XOR, 5, 3, 4));
		// Register 0 is given a non-zero result just before it is read as an operand.
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 0, 0, 16'h0123));
		code.push_back(enc_alu(cpu_pkg::F_SUB, 1, 0, 5));
		code.push_back(enc_alu(cpu_pkg::F_ADD, 1, 1, 2));
		add_row("forwarding", 28, -1);
		// Each load is followed by one independent instruction.
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 2, 0, take_bits16()));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 3, 0, take_bits16()));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 8, 0, 16'h0040));
		code.push_back(enc_imm(cpu_pkg::OP_SW, 2, 0, 16'h0008));
		code.push_back(enc_imm(cpu_pkg::OP_SW, 3, 8, 16'h0014));
		code.push_back(enc_imm(cpu_pkg::OP_LW, 4, 0, 16'h0008));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 6, 0, 16'h0001));
		code.push_back(enc_imm(cpu_pkg::OP_LW, 5, 8, 16'h0014));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 7, 0, 16'h0002));
		code.push_back(enc_alu(cpu_pkg::F_SUB, 1, 4, 5));
		add_row("memory", 32, -1);
		a = take_bits16() | 16'h0001;
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 1, 0, a));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 2, 0, a));
		code.push_back(enc_imm(cpu_pkg::OP_BEQ, 2, 1, 16'h0002));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 1, 0, take_bits16()));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 1, 1, 16'h0100));
		code.push_back(enc_imm(cpu_pkg::OP_BNE, 0, 1, 16'h0001));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 1, 0, take_bits16()));
		add_row("branch_taken", 32, 2);
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 1, 0, take_bits16() | 16'h0001));
		code.push_back(enc_imm(cpu_pkg::OP_BEQ, 0, 1, 16'h0003));
		code.push_back(enc_imm(cpu_pkg::OP_ADDI, 1, 1, take_bits16()));
		code.push_back(enc_imm(cpu_pkg::OP_BNE, 1, 1, 16'h0003));
		code.push_back(enc_alu(cpu_pkg::F_ADD, 1, 1, 1));
		add_row("branch_not_taken", 28, -1);
	endtask

	// Loads a program under reset and follows it for the row's cycle budget.
	task automatic run_row(int r);
		cpu_pkg::word_t prog [PROG_WORDS];
		cpu_pkg::word_t chk_addr, target;
		int fetch_at;
		int base;
		prog = row_prog[r];
		base = int'(RESET_PC >> 2);
		@(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < 64; i++) begin
			imem[i] <= '0;
		end
		for (int i = 0; i < PROG_WORDS; i++) begin
			imem[base + i] <= prog[i];
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_pc({row_name[r], " after reset"}, RESET_PC, instrmem_addr);
		check_word({row_name[r], " after reset"}, '0, debug_out);
		chk_addr = RESET_PC + cpu_pkg::word_t'(4 * row_chk[r]);
		target = branch_target(chk_addr, prog[row_chk[r]]);
		fetch_at = -1;
		for (int c = 0; c < row_budget[r]; c++) begin
			if (c > 0) @(negedge clk);
			if (fetch_at >= 0 && c == fetch_at + 3) begin
				check_pc({row_name[r], " branch target"}, target, instrmem_addr);
			end
			if (fetch_at < 0 && instrmem_addr == chk_addr) fetch_at = c;
		end
		if (fetch_at < 0 || fetch_at + 3 >= row_budget[r]) begin
			errors++;
			$display("%s: the branch at %h was not followed within the cycle budget",
				row_name[r], chk_addr);
			$display("RESULT: FAIL");
			$fatal(1, "branch check incomplete");
		end
		check_word(row_name[r], reference_r1(prog, row_len[r], RESET_PC), debug_out);
	endtask

	initial begin
		build_table();
		for (int r = 0; r < nrows; r++) begin
			wd_cycles += (row_budget[r] + 4) * 2;
		end
		for (int r = 0; r < nrows; r++) begin
			run_row(r);
		end
		if (errors == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("RESULT: FAIL");
			$fatal(1, "%0d checks failed", errors);
		end
	end

endmodule

// ==== verilog/cpu.sv ====
// Processor top level: pipeline stages, interfaces and the two forwarding units.
`timescale 1ns/1ps

module cpu #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0,
	parameter int DMEM_WORDS = 64,
	parameter int DEBUG_REG = 1
) (
	input logic clk,
	input logic rst,
	output cpu_pkg::word_t instrmem_addr,
	input cpu_pkg::word_t instrmem_data,
	output cpu_pkg::word_t debug_out
);

	if2id_if if2id ();
	id2ex_if id2ex ();
	ex2mem_if ex2mem ();

	cpu_pkg::reg_addr_t wb_addr;
	cpu_pkg::word_t wb_data;
	logic branch_taken;
	cpu_pkg::word_t branch_dest;
	logic rs_forward, rt_forward;
	cpu_pkg::word_t rs_forward_data, rt_forward_data;

	//////////////////////////////
	// Forwarding.
	forward fwd_rs (.src_addr(id2ex.rs_addr),
		.ex2mem_rd(ex2mem.rd), .ex2mem_wb_src(ex2mem.wb_src),
		.ex2mem_alu_result(ex2mem.alu_result),
		.wb_addr(wb_addr), .wb_data(wb_data),
		.forward_enable(rs_forward), .forward_data(rs_forward_data));

	forward fwd_rt (.src_addr(id2ex.rt_addr),
		.ex2mem_rd(ex2mem.rd), .ex2mem_wb_src(ex2mem.wb_src),
		.ex2mem_alu_result(ex2mem.alu_result),
		.wb_addr(wb_addr), .wb_data(wb_data),
		.forward_enable(rt_forward), .forward_data(rt_forward_data));

	//////////////////////////////
	// Pipeline stages.
	stage_if #(.RESET_PC(RESET_PC)) u_if (.clk(clk), .rst(rst),
		.branch_taken(branch_taken), .branch_dest(branch_dest),
		.mem_addr(instrmem_addr), .mem_data(instrmem_data), .if2id(if2id));

	stage_id #(.DEBUG_REG(DEBUG_REG)) u_id (.clk(clk), .rst(rst), .if2id(if2id),
		.branch_taken(branch_taken), .wb_addr(wb_addr), .wb_data(wb_data),
		.id2ex(id2ex), .debug_out(debug_out));

	stage_ex u_ex (.clk(clk), .rst(rst), .id2ex(id2ex),
		.rs_forward(rs_forward), .rt_forward(rt_forward),
		.rs_forward_data(rs_forward_data), .rt_forward_data(rt_forward_data),
		.branch_taken(branch_taken), .branch_dest(branch_dest), .ex2mem(ex2mem));

	stage_mem #(.DMEM_WORDS(DMEM_WORDS)) u_mem (.clk(clk), .rst(rst), .ex2mem(ex2mem),
		.wb_addr(wb_addr), .wb_data(wb_data));

endmodule

// ==== verilog/cpu_pkg.sv ====
// Word and register types, opcode/ALU/writeback/branch/immediate enums, instruction fields.
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// Opcode 0 with funct 0 is add r0, r0, r0, so an all-zero word is a NOP.
	typedef enum logic [5:0] {
		OP_ALU  = 6'h00,
		OP_BEQ  = 6'h04,
		OP_BNE  = 6'h05,
		OP_ADDI = 6'h08,
		OP_LUI  = 6'h0f,
		OP_LW   = 6'h23,
		OP_SW   = 6'h2b
	} opcode_e;

	typedef enum logic [3:0] {
		F_ADD = 4'h0,
		F_SUB = 4'h1,
		F_AND = 4'h2,
		F_OR  = 4'h3,
		F_XOR = 4'h4,
		F_SLT = 4'h5
	} funct_e;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT, PASS_B} alu_op_e;
	typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM} wb_src_e;
	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} br_kind_e;
	typedef enum logic [1:0] {IMM_SIGN, IMM_UPPER, IMM_NONE} imm_kind_e;

	//////////////////////////////
	// Instruction field positions.
	localparam int OPCODE_HI = 31;
	localparam int OPCODE_LO = 26;
	localparam int RD_HI = 25;
	localparam int RD_LO = 21;
	localparam int RS_HI = 20;
	localparam int RS_LO = 16;
	localparam int RT_HI = 15;
	localparam int RT_LO = 11;
	localparam int FUNCT_HI = 3;
	localparam int FUNCT_LO = 0;
	localparam int IMM_HI = 15;
	localparam int IMM_LO = 0;

endpackage

// ==== verilog/decode_ctrl.sv ====
// Control decoder: opcode and funct to ALU operation, writeback source, branch and immediate kind.
`timescale 1ns/1ps

module decode_ctrl (
	input cpu_pkg::word_t instr,
	input logic valid,
	output cpu_pkg::alu_op_e alu_op,
	output cpu_pkg::wb_src_e wb_src,
	output cpu_pkg::br_kind_e br_kind,
	output cpu_pkg::imm_kind_e imm_kind,
	output logic is_store,
	output logic use_imm
);

	cpu_pkg::opcode_e opcode;
	cpu_pkg::funct_e funct;
	logic known;

	assign opcode = cpu_pkg::opcode_e'(instr[cpu_pkg::OPCODE_HI:cpu_pkg::OPCODE_LO]);
	assign funct = cpu_pkg::funct_e'(instr[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO]);

	always_comb begin
		alu_op = cpu_pkg::ADD;
		wb_src = cpu_pkg::WB_NONE;
		br_kind = cpu_pkg::BR_NONE;
		imm_kind = cpu_pkg::IMM_NONE;
		is_store = 1'b0;
		use_imm = 1'b0;
		known = 1'b1;
		case (opcode)
			cpu_pkg::OP_ALU: begin
				wb_src = cpu_pkg::WB_ALU;
				case (funct)
					cpu_pkg::F_ADD: alu_op = cpu_pkg::ADD;
					cpu_pkg::F_SUB: alu_op = cpu_pkg::SUB;
					cpu_pkg::F_AND: alu_op = cpu_pkg::AND;
					cpu_pkg::F_OR: alu_op = cpu_pkg::OR;
					cpu_pkg::F_XOR: alu_op = cpu_pkg::XOR;
					cpu_pkg::F_SLT: alu_op = cpu_pkg::SLT;
					default: known = 1'b0;
				endcase
			end
			cpu_pkg::OP_ADDI, cpu_pkg::OP_LW, cpu_pkg::OP_SW: begin
				imm_kind = cpu_pkg::IMM_SIGN;
				use_imm = 1'b1;
				if (opcode == cpu_pkg::OP_ADDI) wb_src = cpu_pkg::WB_ALU;
				if (opcode == cpu_pkg::OP_LW) wb_src = cpu_pkg::WB_MEM;
				if (opcode == cpu_pkg::OP_SW) is_store = 1'b1;
			end
			cpu_pkg::OP_LUI: begin
				alu_op = cpu_pkg::PASS_B;
				wb_src = cpu_pkg::WB_ALU;
				imm_kind = cpu_pkg::IMM_UPPER;
				use_imm = 1'b1;
			end
			cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
				alu_op = cpu_pkg::SUB;
				imm_kind = cpu_pkg::IMM_SIGN;
				br_kind = (opcode == cpu_pkg::OP_BEQ) ? cpu_pkg::BR_EQ : cpu_pkg::BR_NE;
			end
			default: known = 1'b0;
		endcase

		// Empty or undecodable slots leave the pipeline as bubbles.
		if (!valid || !known) begin
			wb_src = cpu_pkg::WB_NONE;
			br_kind = cpu_pkg::BR_NONE;
			is_store = 1'b0;
		end
		if (valid) begin
			assert (known) else $error("unknown instruction %h", instr);
		end
	end

endmodule

// ==== verilog/forward.sv ====
// Forwarding unit picking the newest in-flight value for one source register.
`timescale 1ns/1ps

module forward (
	input cpu_pkg::reg_addr_t src_addr,
	input cpu_pkg::reg_addr_t ex2mem_rd,
	input cpu_pkg::wb_src_e ex2mem_wb_src,
	input cpu_pkg::word_t ex2mem_alu_result,
	input cpu_pkg::reg_addr_t wb_addr,
	input cpu_pkg::word_t wb_data,
	output logic forward_enable,
	output cpu_pkg::word_t forward_data
);

	// The EX/MEM entry is younger than writeback, so it is checked first.
	always_comb begin
		forward_enable = 1'b0;
		forward_data = '0;
		if (src_addr != '0) begin
			if (src_addr == ex2mem_rd && ex2mem_wb_src == cpu_pkg::WB_ALU) begin
				forward_enable = 1'b1;
				forward_data = ex2mem_alu_result;
			end else if (src_addr == wb_addr) begin
				forward_enable = 1'b1;
				forward_data = wb_data;
			end
		end
	end

endmodule

// ==== verilog/pipe_ifs.sv ====
// Pipeline stage interfaces if2id_if, id2ex_if and ex2mem_if with their modports.
`timescale 1ns/1ps

interface if2id_if;
	cpu_pkg::word_t pc;
	cpu_pkg::word_t instr;
	logic valid;

	modport source (output pc, instr, valid);
	modport sink (input pc, instr, valid);
endinterface

interface id2ex_if;
	logic valid;
	cpu_pkg::word_t pc;
	cpu_pkg::alu_op_e alu_op;
	cpu_pkg::wb_src_e wb_src;
	cpu_pkg::br_kind_e br_kind;
	logic is_store;
	logic use_imm;
	cpu_pkg::reg_addr_t rd;
	cpu_pkg::reg_addr_t rs_addr;
	cpu_pkg::reg_addr_t rt_addr;
	cpu_pkg::word_t rs_val;
	cpu_pkg::word_t rt_val;
	cpu_pkg::word_t imm;

	modport source (output valid, pc, alu_op, wb_src, br_kind, is_store, use_imm,
		rd, rs_addr, rt_addr, rs_val, rt_val, imm);
	modport sink (input valid, pc, alu_op, wb_src, br_kind, is_store, use_imm,
		rd, rs_addr, rt_addr, rs_val, rt_val, imm);
endinterface

interface ex2mem_if;
	logic valid;
	cpu_pkg::word_t alu_result;
	cpu_pkg::word_t store_val;
	cpu_pkg::wb_src_e wb_src;
	logic is_store;
	cpu_pkg::reg_addr_t rd;

	modport source (output valid, alu_result, store_val, wb_src, is_store, rd);
	modport sink (input valid, alu_result, store_val, wb_src, is_store, rd);
endinterface

// ==== verilog/stage_ex.sv ====
// Execute stage: operand forwarding, ALU, branch resolution and the EX/MEM register.
`timescale 1ns/1ps

module stage_ex (
	input logic clk,
	input logic rst,
	id2ex_if.sink id2ex,
	input logic rs_forward,
	input logic rt_forward,
	input cpu_pkg::word_t rs_forward_data,
	input cpu_pkg::word_t rt_forward_data,
	output logic branch_taken,
	output cpu_pkg::word_t branch_dest,
	ex2mem_if.source ex2mem
);

	cpu_pkg::word_t rs_op, rt_op, alu_b, alu_out;
	logic operands_equal;

	assign rs_op = rs_forward ? rs_forward_data : id2ex.rs_val;
	assign rt_op = rt_forward ? rt_forward_data : id2ex.rt_val;
	assign alu_b = id2ex.use_imm ? id2ex.imm : rt_op;

	always_comb begin
		case (id2ex.alu_op)
			cpu_pkg::ADD: alu_out = rs_op + alu_b;
			cpu_pkg::SUB: alu_out = rs_op - alu_b;
			cpu_pkg::AND: alu_out = rs_op & alu_b;
			cpu_pkg::OR: alu_out = rs_op | alu_b;
			cpu_pkg::XOR: alu_out = rs_op ^ alu_b;
			cpu_pkg::SLT: alu_out = {31'b0, $signed(rs_op) < $signed(alu_b)};
			cpu_pkg::PASS_B: alu_out = alu_b;
			default: alu_out = '0;
		endcase
	end

	//////////////////////////////
	// Branch resolution.
	assign operands_equal = (rs_op == rt_op);
	assign branch_dest = id2ex.pc + 32'd4 + {id2ex.imm[29:0], 2'b00};

	always_comb begin
		branch_taken = 1'b0;
		if (id2ex.valid) begin
			case (id2ex.br_kind)
				cpu_pkg::BR_EQ: branch_taken = operands_equal;
				cpu_pkg::BR_NE: branch_taken = !operands_equal;
				default: branch_taken = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex2mem.valid <= 1'b0;
			ex2mem.wb_src <= cpu_pkg::WB_NONE;
			ex2mem.is_store <= 1'b0;
		end else begin
			ex2mem.valid <= id2ex.valid;
			ex2mem.wb_src <= id2ex.valid ? id2ex.wb_src : cpu_pkg::WB_NONE;
			ex2mem.is_store <= id2ex.valid && id2ex.is_store;
		end
		ex2mem.alu_result <= alu_out;
		ex2mem.store_val <= rt_op;
		ex2mem.rd <= id2ex.rd;
	end

endmodule

// ==== verilog/stage_id.sv ====
// Decode stage: register file with write-first bypass, immediate extension, ID/EX register.
`timescale 1ns/1ps

module stage_id #(
	parameter int DEBUG_REG = 1
) (
	input logic clk,
	input logic rst,
	if2id_if.sink if2id,
	input logic branch_taken,
	input cpu_pkg::reg_addr_t wb_addr,
	input cpu_pkg::word_t wb_data,
	id2ex_if.source id2ex,
	output cpu_pkg::word_t debug_out
);

	localparam cpu_pkg::reg_addr_t DBG_ADDR = cpu_pkg::reg_addr_t'(DEBUG_REG);

	cpu_pkg::word_t regs [32];
	cpu_pkg::alu_op_e alu_op;
	cpu_pkg::wb_src_e wb_src;
	cpu_pkg::br_kind_e br_kind;
	cpu_pkg::imm_kind_e imm_kind;
	logic is_store, use_imm;
	cpu_pkg::reg_addr_t rd_f, rs_f, rt_f, rt_sel;
	logic [15:0] imm16;
	cpu_pkg::word_t imm_ext;

	// A write in this cycle is seen by a read in the same cycle.
	function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_addr_t a, cpu_pkg::word_t stored,
		cpu_pkg::reg_addr_t wa, cpu_pkg::word_t wd);
		if (a == '0) return '0;
		if (a == wa) return wd;
		return stored;
	endfunction

	decode_ctrl u_ctrl (.instr(if2id.instr), .valid(if2id.valid), .alu_op(alu_op),
		.wb_src(wb_src), .br_kind(br_kind), .imm_kind(imm_kind),
		.is_store(is_store), .use_imm(use_imm));

	assign rd_f = if2id.instr[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
	assign rs_f = if2id.instr[cpu_pkg::RS_HI:cpu_pkg::RS_LO];
	assign rt_f = if2id.instr[cpu_pkg::RT_HI:cpu_pkg::RT_LO];
	assign imm16 = if2id.instr[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO];

	// Stores and branches take their second source from the rd field.
	assign rt_sel = (is_store || br_kind != cpu_pkg::BR_NONE) ? rd_f : (use_imm ? '0 : rt_f);

	always_comb begin
		case (imm_kind)
			cpu_pkg::IMM_SIGN: imm_ext = {{16{imm16[15]}}, imm16};
			cpu_pkg::IMM_UPPER: imm_ext = {imm16, 16'h0000};
			default: imm_ext = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wb_addr != '0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	assign debug_out = read_port(DBG_ADDR, regs[DBG_ADDR], wb_addr, wb_data);

	//////////////////////////////
	// ID/EX register.
	always_ff @(posedge clk) begin
		if (rst || branch_taken) begin
			id2ex.valid <= 1'b0;
			id2ex.wb_src <= cpu_pkg::WB_NONE;
			id2ex.br_kind <= cpu_pkg::BR_NONE;
			id2ex.is_store <= 1'b0;
		end else begin
			id2ex.valid <= if2id.valid;
			id2ex.wb_src <= wb_src;
			id2ex.br_kind <= br_kind;
			id2ex.is_store <= is_store;
		end
		id2ex.pc <= if2id.pc;
		id2ex.alu_op <= alu_op;
		id2ex.use_imm <= use_imm;
		id2ex.rd <= rd_f;
		id2ex.rs_addr <= rs_f;
		id2ex.rt_addr <= rt_sel;
		id2ex.rs_val <= read_port(rs_f, regs[rs_f], wb_addr, wb_data);
		id2ex.rt_val <= read_port(rt_sel, regs[rt_sel], wb_addr, wb_data);
		id2ex.imm <= imm_ext;
	end

	reg0_zero: assert property (@(posedge clk) regs[0] == '0)
		else $error("register 0 holds %h", regs[0]);

endmodule

// ==== verilog/stage_if.sv ====
// Fetch stage: program counter, instruction port and the IF/ID register.
`timescale 1ns/1ps

module stage_if #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0
) (
	input logic clk,
	input logic rst,
	input logic branch_taken,
	input cpu_pkg::word_t branch_dest,
	output cpu_pkg::word_t mem_addr,
	input cpu_pkg::word_t mem_data,
	if2id_if.source if2id
);

	cpu_pkg::word_t pc;

	assign mem_addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (branch_taken) begin
			pc <= branch_dest;
		end else begin
			pc <= pc + 32'd4;
		end
	end

	// The slot fetched while a branch resolves is squashed.
	always_ff @(posedge clk) begin
		if (rst || branch_taken) begin
			if2id.valid <= 1'b0;
		end else begin
			if2id.valid <= 1'b1;
		end
		if2id.pc <= pc;
		if2id.instr <= mem_data;
	end

	pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("fetch address %h is not word-aligned", pc);

endmodule

// ==== verilog/stage_mem.sv ====
// Memory stage: data RAM, load and store, and the writeback register.
`timescale 1ns/1ps

module stage_mem #(
	parameter int DMEM_WORDS = 64
) (
	input logic clk,
	input logic rst,
	ex2mem_if.sink ex2mem,
	output cpu_pkg::reg_addr_t wb_addr,
	output cpu_pkg::word_t wb_data
);

	localparam int AW = $clog2(DMEM_WORDS);

	cpu_pkg::word_t ram [DMEM_WORDS];
	logic [AW-1:0] word_idx;
	cpu_pkg::word_t load_data;
	logic mem_access;

	// Byte address to word index.
	assign word_idx = ex2mem.alu_result[AW+1:2];
	assign load_data = ram[word_idx];
	assign mem_access = ex2mem.valid &&
		(ex2mem.is_store || ex2mem.wb_src == cpu_pkg::WB_MEM);

	always_ff @(posedge clk) begin
		if (ex2mem.valid && ex2mem.is_store) begin
			ram[word_idx] <= ex2mem.store_val;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_addr <= '0;
		end else begin
			wb_addr <= (ex2mem.valid && ex2mem.wb_src != cpu_pkg::WB_NONE) ? ex2mem.rd : '0;
		end
		wb_data <= (ex2mem.wb_src == cpu_pkg::WB_MEM) ? load_data : ex2mem.alu_result;
	end

	dmem_range: assert property (@(posedge clk) disable iff (rst)
		mem_access |-> {2'b00, ex2mem.alu_result[31:2]} < cpu_pkg::word_t'(DMEM_WORDS))
		else $error("data access at %h outside RAM", ex2mem.alu_result);

endmodule
